/* rtl/dc_defs.svh */
`ifndef DC_DEFS_SVH
`define DC_DEFS_SVH

// ============================================================
// queue and bus geometry
// ============================================================

// request queue depth
`define DC_SLOTS 4

// cpu side carries a whole line, the bus moves half a line
`define DC_LINE_BITS 512
`define DC_HALF_BITS 256
`define DC_LINE_SEL 64
`define DC_HALF_SEL 32

// byte address and cpu transaction id
`define DC_ADDR_BITS 32
`define DC_TID_BITS 4

// channel id this controller stamps into its bus tags
`define DC_CHANNEL 2'd1

`endif

/* rtl/bus_pkg.sv */
`default_nettype none

`include "dc_defs.svh"

package bus_pkg;

	// tag width is channel + slot + half
	localparam int TAG_BITS = 3 + $clog2(`DC_SLOTS);

	// selects lower (0) or upper (1) half of the line
	typedef logic half_t;

	// structured view of a bus tag
	typedef struct packed {
		logic [1:0] channel;
		logic [$clog2(`DC_SLOTS)-1:0] slot;
		half_t half;
	} tag_fields_t;

	// the bus only echoes the raw word back,
	// the controller builds and decodes it by field
	typedef union packed {
		logic [TAG_BITS-1:0] raw;
		tag_fields_t fields;
	} bus_tag_t;

endpackage

`default_nettype wire

/* rtl/req_pkg.sv */
`default_nettype none

`include "dc_defs.svh"

package req_pkg;

	// index of a request queue entry
	typedef logic [$clog2(`DC_SLOTS)-1:0] slot_t;

	// one queued cpu request
	typedef struct packed {
		logic busy;
		logic we;
		logic [`DC_ADDR_BITS-1:0] adr;
		logic [`DC_LINE_SEL-1:0] sel;
		logic [`DC_LINE_BITS-1:0] dat;
		logic [`DC_TID_BITS-1:0] tid;
		// half still waiting to go out on the bus
		logic [1:0] pend;
		// half answered, or never needed
		logic [1:0] done;
	} slot_rec_t;

endpackage

`default_nettype wire

/* rtl/req_queue.sv */
`default_nettype none

`include "dc_defs.svh"

module req_queue import bus_pkg::*, req_pkg::*; (
	input wire logic clk_i,
	input wire logic rst_i,
	input wire logic cpu_req_valid_i,
	input wire logic cpu_req_we_i,
	input wire logic [`DC_ADDR_BITS-1:0] cpu_req_adr_i,
	input wire logic [`DC_LINE_SEL-1:0] cpu_req_sel_i,
	input wire logic [`DC_LINE_BITS-1:0] cpu_req_dat_i,
	input wire logic [`DC_TID_BITS-1:0] cpu_req_tid_i,
	input wire logic issue_take_i,
	input wire slot_t issue_slot_i,
	input wire half_t issue_half_i,
	input wire logic done_valid_i,
	input wire slot_t done_slot_i,
	input wire half_t done_half_i,
	output logic cpu_req_ready_o,
	output logic [2*`DC_SLOTS-1:0] pend_mask_o,
	output logic pick_we_o,
	output logic [`DC_ADDR_BITS-1:0] pick_adr_o,
	output logic [`DC_HALF_SEL-1:0] pick_sel_o,
	output logic [`DC_HALF_BITS-1:0] pick_dat_o,
	output logic cpu_resp_valid_o,
	output logic [`DC_TID_BITS-1:0] cpu_resp_tid_o,
	output logic retire_o,
	output slot_t retire_slot_o
);

	slot_rec_t q [`DC_SLOTS];
	slot_rec_t pick;
	slot_t free_slot;
	logic free_any;
	logic accept;

	// ============================================================
	// slot search
	// ============================================================

	// lowest idle slot takes the next request
	always_comb begin
		free_slot = '0;
		free_any = 1'b0;
		for (int i = `DC_SLOTS-1; i >= 0; i--) begin
			if (!q[i].busy) begin
				free_slot = slot_t'(i);
				free_any = 1'b1;
			end
		end
	end

	// lowest slot with both halves done retires first
	always_comb begin
		retire_slot_o = '0;
		retire_o = 1'b0;
		for (int i = `DC_SLOTS-1; i >= 0; i--) begin
			if (q[i].busy && (&q[i].done)) begin
				retire_slot_o = slot_t'(i);
				retire_o = 1'b1;
			end
		end
	end

	// a busy slot is never picked for a new request,
	// so a retire in the same cycle does not collide
	assign cpu_req_ready_o = free_any;
	assign accept = cpu_req_valid_i && free_any;

	// pending halves, two bits per slot, lower half in the even bit
	always_comb begin
		for (int i = 0; i < `DC_SLOTS; i++)
			pend_mask_o[2*i +: 2] = q[i].pend;
	end

	// ============================================================
	// half picked by the issue stage
	// ============================================================

	assign pick = q[issue_slot_i];
	assign pick_we_o = pick.we;
	// line address, half bit at bit 5, low bits zero
	assign pick_adr_o = {pick.adr[`DC_ADDR_BITS-1:6], issue_half_i, 5'b0};
	assign pick_sel_o = issue_half_i ? pick.sel[`DC_LINE_SEL-1:`DC_HALF_SEL]
		: pick.sel[`DC_HALF_SEL-1:0];
	assign pick_dat_o = issue_half_i ? pick.dat[`DC_LINE_BITS-1:`DC_HALF_BITS]
		: pick.dat[`DC_HALF_BITS-1:0];

	// ============================================================
	// slot update
	// ============================================================

	always_ff @(posedge clk_i) begin
		// request payload
		if (accept) begin
			q[free_slot].we <= cpu_req_we_i;
			q[free_slot].adr <= cpu_req_adr_i;
			q[free_slot].sel <= cpu_req_sel_i;
			q[free_slot].dat <= cpu_req_dat_i;
			q[free_slot].tid <= cpu_req_tid_i;
		end
		// tid goes out with the response pulse
		if (retire_o)
			cpu_resp_tid_o <= q[retire_slot_o].tid;

		if (rst_i) begin
			for (int i = 0; i < `DC_SLOTS; i++) begin
				q[i].busy <= 1'b0;
				q[i].pend <= 2'b00;
				q[i].done <= 2'b00;
			end
			cpu_resp_valid_o <= 1'b0;
		end else begin
			cpu_resp_valid_o <= retire_o;
			if (retire_o) begin
				q[retire_slot_o].busy <= 1'b0;
				q[retire_slot_o].done <= 2'b00;
			end
			// half loaded into the bus output register
			if (issue_take_i)
				q[issue_slot_i].pend[issue_half_i] <= 1'b0;
			// half answered on the bus
			if (done_valid_i)
				q[done_slot_i].done[done_half_i] <= 1'b1;
			// a half with no byte enables is done at once
			if (accept) begin
				q[free_slot].busy <= 1'b1;
				q[free_slot].pend[0] <= |cpu_req_sel_i[`DC_HALF_SEL-1:0];
				q[free_slot].pend[1] <= |cpu_req_sel_i[`DC_LINE_SEL-1:`DC_HALF_SEL];
				q[free_slot].done[0] <= ~|cpu_req_sel_i[`DC_HALF_SEL-1:0];
				q[free_slot].done[1] <= ~|cpu_req_sel_i[`DC_LINE_SEL-1:`DC_HALF_SEL];
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/tran_issue.sv */
`default_nettype none

`include "dc_defs.svh"

module tran_issue import bus_pkg::*, req_pkg::*; (
	input wire logic clk_i,
	input wire logic rst_i,
	input wire logic [2*`DC_SLOTS-1:0] pend_mask_i,
	input wire logic pick_we_i,
	input wire logic [`DC_ADDR_BITS-1:0] pick_adr_i,
	input wire logic [`DC_HALF_SEL-1:0] pick_sel_i,
	input wire logic [`DC_HALF_BITS-1:0] pick_dat_i,
	input wire logic bus_req_ready_i,
	output logic issue_take_o,
	output slot_t issue_slot_o,
	output half_t issue_half_o,
	output logic bus_req_valid_o,
	output logic bus_req_we_o,
	output logic [`DC_ADDR_BITS-1:0] bus_req_adr_o,
	output logic [`DC_HALF_SEL-1:0] bus_req_sel_o,
	output logic [`DC_HALF_BITS-1:0] bus_req_dat_o,
	output bus_tag_t bus_req_tag_o
);

	localparam int IDX_W = $clog2(2*`DC_SLOTS);

	logic [IDX_W-1:0] pick_idx;
	logic pick_any;
	bus_tag_t tag_next;

	// lowest pending half wins, slot order then lower half first
	always_comb begin
		pick_idx = '0;
		pick_any = 1'b0;
		for (int i = 2*`DC_SLOTS-1; i >= 0; i--) begin
			if (pend_mask_i[i]) begin
				pick_idx = IDX_W'(i);
				pick_any = 1'b1;
			end
		end
	end

	assign issue_slot_o = pick_idx[IDX_W-1:1];
	assign issue_half_o = pick_idx[0];

	// refill when empty or when the current word leaves this cycle
	assign issue_take_o = pick_any && (!bus_req_valid_o || bus_req_ready_i);

	// tag names the slot and half so the answer can find its way back
	always_comb begin
		tag_next.fields.channel = `DC_CHANNEL;
		tag_next.fields.slot = issue_slot_o;
		tag_next.fields.half = issue_half_o;
	end

	// ============================================================
	// bus request output register
	// ============================================================

	always_ff @(posedge clk_i) begin
		if (rst_i)
			bus_req_valid_o <= 1'b0;
		else if (issue_take_o)
			bus_req_valid_o <= 1'b1;
		else if (bus_req_ready_i)
			bus_req_valid_o <= 1'b0;
	end

	// payload holds while stalled
	always_ff @(posedge clk_i) begin
		if (issue_take_o) begin
			bus_req_we_o <= pick_we_i;
			bus_req_adr_o <= pick_adr_i;
			bus_req_sel_o <= pick_sel_i;
			bus_req_dat_o <= pick_dat_i;
			bus_req_tag_o <= tag_next;
		end
	end

endmodule

`default_nettype wire

/* rtl/resp_collect.sv */
`default_nettype none

`include "dc_defs.svh"

module resp_collect import bus_pkg::*, req_pkg::*; (
	input wire logic clk_i,
	input wire logic rst_i,
	input wire logic bus_resp_valid_i,
	input wire bus_tag_t bus_resp_tag_i,
	input wire logic [`DC_HALF_BITS-1:0] bus_resp_dat_i,
	input wire logic bus_resp_err_i,
	input wire logic issue_take_i,
	input wire slot_t issue_slot_i,
	input wire half_t issue_half_i,
	input wire logic retire_i,
	input wire slot_t retire_slot_i,
	output logic done_valid_o,
	output slot_t done_slot_o,
	output half_t done_half_o,
	output logic [`DC_LINE_BITS-1:0] cpu_resp_dat_o,
	output logic cpu_resp_err_o
);

	// one bit per slot half on the bus and not yet answered
	logic [2*`DC_SLOTS-1:0] outst;
	// line buffers, one per slot, split by half
	logic [`DC_HALF_BITS-1:0] line_buf [`DC_SLOTS][2];
	// halves received so far, unreceived halves read as zero
	logic [1:0] got [`DC_SLOTS];
	logic [`DC_SLOTS-1:0] err_buf;
	slot_t rsp_slot;
	half_t rsp_half;
	logic hit;

	// ============================================================
	// tag decode
	// ============================================================

	assign rsp_slot = bus_resp_tag_i.fields.slot;
	assign rsp_half = bus_resp_tag_i.fields.half;
	// foreign channel or stale tag is dropped
	assign hit = bus_resp_valid_i && (bus_resp_tag_i.fields.channel == `DC_CHANNEL)
		&& outst[{rsp_slot, rsp_half}];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			outst <= '0;
			err_buf <= '0;
			done_valid_o <= 1'b0;
			for (int i = 0; i < `DC_SLOTS; i++)
				got[i] <= 2'b00;
		end else begin
			done_valid_o <= hit;
			// retired slot starts clean for its next request
			if (retire_i) begin
				got[retire_slot_i] <= 2'b00;
				err_buf[retire_slot_i] <= 1'b0;
			end
			if (hit) begin
				outst[{rsp_slot, rsp_half}] <= 1'b0;
				got[rsp_slot][rsp_half] <= 1'b1;
				// error is sticky over both halves
				err_buf[rsp_slot] <= err_buf[rsp_slot] | bus_resp_err_i;
			end
			if (issue_take_i)
				outst[{issue_slot_i, issue_half_i}] <= 1'b1;
		end
	end

	// ============================================================
	// line data and cpu response
	// ============================================================

	always_ff @(posedge clk_i) begin
		if (hit) begin
			line_buf[rsp_slot][rsp_half] <= bus_resp_dat_i;
			done_slot_o <= rsp_slot;
			done_half_o <= rsp_half;
		end
		// lands with the response pulse from the queue
		if (retire_i) begin
			cpu_resp_dat_o <= {
				line_buf[retire_slot_i][1] & {`DC_HALF_BITS{got[retire_slot_i][1]}},
				line_buf[retire_slot_i][0] & {`DC_HALF_BITS{got[retire_slot_i][0]}}
			};
			cpu_resp_err_o <= err_buf[retire_slot_i];
		end
	end

endmodule

`default_nettype wire

/* rtl/dcache_ctrl_top.sv */
`default_nettype none

`include "dc_defs.svh"

module dcache_ctrl_top import bus_pkg::*, req_pkg::*; (
	input wire logic clk_i,
	input wire logic rst_i,
	// cpu request
	input wire logic cpu_req_valid_i,
	output logic cpu_req_ready_o,
	input wire logic cpu_req_we_i,
	input wire logic [`DC_ADDR_BITS-1:0] cpu_req_adr_i,
	input wire logic [`DC_LINE_SEL-1:0] cpu_req_sel_i,
	input wire logic [`DC_LINE_BITS-1:0] cpu_req_dat_i,
	input wire logic [`DC_TID_BITS-1:0] cpu_req_tid_i,
	// cpu response
	output logic cpu_resp_valid_o,
	output logic [`DC_TID_BITS-1:0] cpu_resp_tid_o,
	output logic [`DC_LINE_BITS-1:0] cpu_resp_dat_o,
	output logic cpu_resp_err_o,
	// bus request
	output logic bus_req_valid_o,
	input wire logic bus_req_ready_i,
	output logic bus_req_we_o,
	output logic [`DC_ADDR_BITS-1:0] bus_req_adr_o,
	output logic [`DC_HALF_SEL-1:0] bus_req_sel_o,
	output logic [`DC_HALF_BITS-1:0] bus_req_dat_o,
	output bus_tag_t bus_req_tag_o,
	// bus response
	input wire logic bus_resp_valid_i,
	input wire bus_tag_t bus_resp_tag_i,
	input wire logic [`DC_HALF_BITS-1:0] bus_resp_dat_i,
	input wire logic bus_resp_err_i
);

	// queue to issue stage
	logic [2*`DC_SLOTS-1:0] pend_mask;
	logic pick_we;
	logic [`DC_ADDR_BITS-1:0] pick_adr;
	logic [`DC_HALF_SEL-1:0] pick_sel;
	logic [`DC_HALF_BITS-1:0] pick_dat;

	// issue handshake, seen by queue and collector
	logic issue_take;
	slot_t issue_slot;
	half_t issue_half;

	// collector to queue
	logic done_valid;
	slot_t done_slot;
	half_t done_half;

	// queue to collector
	logic retire;
	slot_t retire_slot;

	req_queue u_req_queue (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.cpu_req_valid_i(cpu_req_valid_i),
		.cpu_req_we_i(cpu_req_we_i),
		.cpu_req_adr_i(cpu_req_adr_i),
		.cpu_req_sel_i(cpu_req_sel_i),
		.cpu_req_dat_i(cpu_req_dat_i),
		.cpu_req_tid_i(cpu_req_tid_i),
		.issue_take_i(issue_take),
		.issue_slot_i(issue_slot),
		.issue_half_i(issue_half),
		.done_valid_i(done_valid),
		.done_slot_i(done_slot),
		.done_half_i(done_half),
		.cpu_req_ready_o(cpu_req_ready_o),
		.pend_mask_o(pend_mask),
		.pick_we_o(pick_we),
		.pick_adr_o(pick_adr),
		.pick_sel_o(pick_sel),
		.pick_dat_o(pick_dat),
		.cpu_resp_valid_o(cpu_resp_valid_o),
		.cpu_resp_tid_o(cpu_resp_tid_o),
		.retire_o(retire),
		.retire_slot_o(retire_slot)
	);

	tran_issue u_tran_issue (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.pend_mask_i(pend_mask),
		.pick_we_i(pick_we),
		.pick_adr_i(pick_adr),
		.pick_sel_i(pick_sel),
		.pick_dat_i(pick_dat),
		.bus_req_ready_i(bus_req_ready_i),
		.issue_take_o(issue_take),
		.issue_slot_o(issue_slot),
		.issue_half_o(issue_half),
		.bus_req_valid_o(bus_req_valid_o),
		.bus_req_we_o(bus_req_we_o),
		.bus_req_adr_o(bus_req_adr_o),
		.bus_req_sel_o(bus_req_sel_o),
		.bus_req_dat_o(bus_req_dat_o),
		.bus_req_tag_o(bus_req_tag_o)
	);

	resp_collect u_resp_collect (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.bus_resp_valid_i(bus_resp_valid_i),
		.bus_resp_tag_i(bus_resp_tag_i),
		.bus_resp_dat_i(bus_resp_dat_i),
		.bus_resp_err_i(bus_resp_err_i),
		.issue_take_i(issue_take),
		.issue_slot_i(issue_slot),
		.issue_half_i(issue_half),
		.retire_i(retire),
		.retire_slot_i(retire_slot),
		.done_valid_o(done_valid),
		.done_slot_o(done_slot),
		.done_half_o(done_half),
		.cpu_resp_dat_o(cpu_resp_dat_o),
		.cpu_resp_err_o(cpu_resp_err_o)
	);

endmodule

`default_nettype wire

/* test/tb_bus_model.sv */
`default_nettype none

`include "dc_defs.svh"

module tb_bus_model (
	input wire logic clk_i,
	input wire logic rst_i,
	input wire logic hold_i,
	input wire logic req_valid_i,
	output logic req_ready_o,
	input wire logic req_we_i,
	input wire logic [`DC_ADDR_BITS-1:0] req_adr_i,
	input wire logic [`DC_HALF_SEL-1:0] req_sel_i,
	input wire logic [`DC_HALF_BITS-1:0] req_dat_i,
	input wire logic [4:0] req_tag_i,
	output logic resp_valid_o,
	output logic [4:0] resp_tag_o,
	output logic [`DC_HALF_BITS-1:0] resp_dat_o,
	output logic resp_err_o,
	output int handshakes_o
);
	timeunit 1ns;
	timeprecision 1ps;

	// sparse memory, one entry per half line
	logic [`DC_HALF_BITS-1:0] mem [logic [`DC_ADDR_BITS-1:0]];
	// answers waiting to go out, with cycles left
	int wait_q [$];
	logic [4:0] tag_q [$];
	logic [`DC_HALF_BITS-1:0] dat_q [$];
	logic err_q [$];
	logic hold_q;

	// untouched memory reads back its own word addresses, scrambled
	function automatic logic [`DC_HALF_BITS-1:0] fill_half(input logic [31:0] a);
		logic [`DC_HALF_BITS-1:0] v;
		for (int k = 0; k < 8; k++)
			v[32*k +: 32] = (a + 32'(4*k)) ^ 32'h5a5a_c3c3;
		return v;
	endfunction

	initial begin
		req_ready_o = 1'b0;
		resp_valid_o = 1'b0;
		resp_tag_o = '0;
		resp_dat_o = '0;
		resp_err_o = 1'b0;
		handshakes_o = 0;
		hold_q = 1'b0;
	end

	// hold is taken on the rising edge so it is stable at the falling one
	always @(posedge clk_i)
		hold_q <= hold_i;

	always @(negedge clk_i) begin : drive
		logic [`DC_HALF_BITS-1:0] line;
		int pick;
		pick = -1;
		resp_valid_o = 1'b0;
		// age every answer, the first one due goes out
		for (int i = 0; i < wait_q.size(); i++) begin
			wait_q[i] = wait_q[i] - 1;
			if (wait_q[i] <= 0 && pick < 0)
				pick = i;
		end
		if (!rst_i && !hold_q && pick >= 0) begin
			resp_valid_o = 1'b1;
			resp_tag_o = tag_q[pick];
			resp_dat_o = dat_q[pick];
			resp_err_o = err_q[pick];
			wait_q.delete(pick);
			tag_q.delete(pick);
			dat_q.delete(pick);
			err_q.delete(pick);
		end
		req_ready_o = !rst_i && ($urandom % 4 != 0);
		// valid and ready now means the request is taken at the next rising edge
		if (req_valid_i && req_ready_o) begin
			handshakes_o++;
			line = mem.exists(req_adr_i) ? mem[req_adr_i] : fill_half(req_adr_i);
			if (req_we_i) begin
				for (int b = 0; b < `DC_HALF_SEL; b++)
					if (req_sel_i[b])
						line[8*b +: 8] = req_dat_i[8*b +: 8];
				mem[req_adr_i] = line;
				// write answers carry no data
				line = '0;
			end
			wait_q.push_back($urandom_range(8, 1));
			tag_q.push_back(req_tag_i);
			dat_q.push_back(line);
			err_q.push_back(req_adr_i >= 32'hf000_0000);
		end
	end

endmodule

`default_nettype wire

/* test/tb_dcache_ctrl.sv */
`default_nettype none

`include "dc_defs.svh"

module tb_dcache_ctrl;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int LIMIT = 300;
	localparam int TIDS = 1 << `DC_TID_BITS;

	logic clk;
	logic rst;
	logic cpu_req_valid;
	logic cpu_req_ready;
	logic cpu_req_we;
	logic [`DC_ADDR_BITS-1:0] cpu_req_adr;
	logic [`DC_LINE_SEL-1:0] cpu_req_sel;
	logic [`DC_LINE_BITS-1:0] cpu_req_dat;
	logic [`DC_TID_BITS-1:0] cpu_req_tid;
	logic cpu_resp_valid;
	logic [`DC_TID_BITS-1:0] cpu_resp_tid;
	logic [`DC_LINE_BITS-1:0] cpu_resp_dat;
	logic cpu_resp_err;
	logic bus_req_valid;
	logic bus_req_ready;
	logic bus_req_we;
	logic [`DC_ADDR_BITS-1:0] bus_req_adr;
	logic [`DC_HALF_SEL-1:0] bus_req_sel;
	logic [`DC_HALF_BITS-1:0] bus_req_dat;
	logic [4:0] bus_req_tag;
	logic bus_resp_valid;
	logic [4:0] bus_resp_tag;
	logic [`DC_HALF_BITS-1:0] bus_resp_dat;
	logic bus_resp_err;
	// bus model answer before the injection mux
	logic m_valid;
	logic [4:0] m_tag;
	logic [`DC_HALF_BITS-1:0] m_dat;
	logic m_err;
	logic hold;
	logic inj_valid;
	logic [4:0] inj_tag;
	int handshakes;

	// ============================================================
	// scoreboard state
	// ============================================================

	logic [`DC_HALF_BITS-1:0] shadow [logic [`DC_ADDR_BITS-1:0]];
	logic [`DC_LINE_BITS-1:0] exp_dat [TIDS];
	logic exp_err [TIDS];
	logic waiting [TIDS];
	int acc_cyc [TIDS];
	int resp_cyc [TIDS];
	int cycle;
	int errors;
	int checks;
	int tests;
	int err_mark;

	always #2 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	// the injected word wins and the model is held while it is on the bus
	assign bus_resp_valid = m_valid | inj_valid;
	assign bus_resp_tag = inj_valid ? inj_tag : m_tag;
	assign bus_resp_dat = inj_valid ? '1 : m_dat;
	assign bus_resp_err = m_err | inj_valid;

	dcache_ctrl_top dut_i (
		.clk_i(clk),
		.rst_i(rst),
		.cpu_req_valid_i(cpu_req_valid),
		.cpu_req_ready_o(cpu_req_ready),
		.cpu_req_we_i(cpu_req_we),
		.cpu_req_adr_i(cpu_req_adr),
		.cpu_req_sel_i(cpu_req_sel),
		.cpu_req_dat_i(cpu_req_dat),
		.cpu_req_tid_i(cpu_req_tid),
		.cpu_resp_valid_o(cpu_resp_valid),
		.cpu_resp_tid_o(cpu_resp_tid),
		.cpu_resp_dat_o(cpu_resp_dat),
		.cpu_resp_err_o(cpu_resp_err),
		.bus_req_valid_o(bus_req_valid),
		.bus_req_ready_i(bus_req_ready),
		.bus_req_we_o(bus_req_we),
		.bus_req_adr_o(bus_req_adr),
		.bus_req_sel_o(bus_req_sel),
		.bus_req_dat_o(bus_req_dat),
		.bus_req_tag_o(bus_req_tag),
		.bus_resp_valid_i(bus_resp_valid),
		.bus_resp_tag_i(bus_resp_tag),
		.bus_resp_dat_i(bus_resp_dat),
		.bus_resp_err_i(bus_resp_err)
	);

	tb_bus_model u_bus (
		.clk_i(clk),
		.rst_i(rst),
		.hold_i(hold),
		.req_valid_i(bus_req_valid),
		.req_ready_o(bus_req_ready),
		.req_we_i(bus_req_we),
		.req_adr_i(bus_req_adr),
		.req_sel_i(bus_req_sel),
		.req_dat_i(bus_req_dat),
		.req_tag_i(bus_req_tag),
		.resp_valid_o(m_valid),
		.resp_tag_o(m_tag),
		.resp_dat_o(m_dat),
		.resp_err_o(m_err),
		.handshakes_o(handshakes)
	);

	// same word pattern as the bus memory starts with
	function automatic logic [`DC_HALF_BITS-1:0] shadow_half(input logic [31:0] a);
		logic [`DC_HALF_BITS-1:0] v;
		if (shadow.exists(a))
			return shadow[a];
		for (int k = 0; k < 8; k++)
			v[32*k +: 32] = (a + 32'(4*k)) ^ 32'h5a5a_c3c3;
		return v;
	endfunction

	// expected error bit sits above the line data
	// only halves with byte enables reach the bus
	function automatic logic [`DC_LINE_BITS:0] ref_resp(input logic we,
			input logic [31:0] adr, input logic [`DC_LINE_SEL-1:0] sel);
		logic [`DC_LINE_BITS:0] r;
		logic [31:0] ha;
		r = '0;
		for (int h = 0; h < 2; h++) begin
			ha = {adr[31:6], 1'(h), 5'b0};
			if (|sel[`DC_HALF_SEL*h +: `DC_HALF_SEL]) begin
				if (!we)
					r[`DC_HALF_BITS*h +: `DC_HALF_BITS] = shadow_half(ha);
				if (ha >= 32'hf000_0000)
					r[`DC_LINE_BITS] = 1'b1;
			end
		end
		return r;
	endfunction

	task automatic check(input string what, input logic [`DC_LINE_BITS-1:0] got,
			input logic [`DC_LINE_BITS-1:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("FAIL %0t %s: got %h want %h", $time, what, got, want);
		end
	endtask

	task automatic give_up(input string why);
		$display("timeout at %0t: %s", $time, why);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic report_test(input string name);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - err_mark);
		err_mark = errors;
	endtask

	// ============================================================
	// stimulus and waits on the falling edge
	// ============================================================

	task automatic send_req(input logic we, input logic [31:0] adr,
			input logic [`DC_LINE_SEL-1:0] sel, input logic [`DC_LINE_BITS-1:0] dat,
			input logic [`DC_TID_BITS-1:0] tid);
		logic [`DC_LINE_BITS:0] r;
		logic [`DC_HALF_BITS-1:0] line;
		logic [31:0] ha;
		int t;
		r = ref_resp(we, adr, sel);
		exp_dat[tid] = r[`DC_LINE_BITS-1:0];
		exp_err[tid] = r[`DC_LINE_BITS];
		waiting[tid] = 1'b1;
		// shadow takes the written bytes
		for (int b = 0; b < `DC_LINE_SEL; b++) begin
			if (we && sel[b]) begin
				ha = {adr[31:6], 1'(b / `DC_HALF_SEL), 5'b0};
				line = shadow_half(ha);
				line[8*(b % `DC_HALF_SEL) +: 8] = dat[8*b +: 8];
				shadow[ha] = line;
			end
		end
		cpu_req_valid = 1'b1;
		cpu_req_we = we;
		cpu_req_adr = adr;
		cpu_req_sel = sel;
		cpu_req_dat = dat;
		cpu_req_tid = tid;
		t = 0;
		while (!cpu_req_ready) begin
			@(negedge clk);
			t++;
			if (t > LIMIT)
				give_up("cpu request was never accepted");
		end
		acc_cyc[tid] = cycle;
		@(negedge clk);
		cpu_req_valid = 1'b0;
	endtask

	task automatic wait_resp(input int tid);
		int t;
		t = 0;
		while (waiting[tid]) begin
			@(negedge clk);
			t++;
			if (t > LIMIT)
				give_up($sformatf("no response for tid %0d", tid));
		end
	endtask

	task automatic wait_handshakes(input int target);
		int t;
		t = 0;
		while (handshakes < target) begin
			@(negedge clk);
			t++;
			if (t > LIMIT)
				give_up("bus requests did not go out");
		end
	endtask

	// compare each cpu response against what was recorded for its tid
	always @(negedge clk) begin : compare
		int t;
		if (!rst && cpu_resp_valid) begin
			t = cpu_resp_tid;
			if (!waiting[t]) begin
				errors++;
				$display("response for tid %0d arrived but none was pending", t);
			end else begin
				check($sformatf("tid %0d data", t), cpu_resp_dat, exp_dat[t]);
				check($sformatf("tid %0d error", t), cpu_resp_err, exp_err[t]);
				resp_cyc[t] = cycle;
				waiting[t] = 1'b0;
			end
		end
	end

	initial begin : run
		int seed;
		int hs;
		int lat;
		logic [`DC_LINE_BITS-1:0] wdat;
		seed = 13992;
		void'($urandom(seed));
		clk = 1'b0;
		rst = 1'b1;
		cpu_req_valid = 1'b0;
		cpu_req_we = 1'b0;
		cpu_req_adr = '0;
		cpu_req_sel = '0;
		cpu_req_dat = '0;
		cpu_req_tid = '0;
		hold = 1'b0;
		inj_valid = 1'b0;
		inj_tag = '0;
		cycle = 0;
		errors = 0;
		checks = 0;
		tests = 0;
		err_mark = 0;
		for (int k = 0; k < TIDS; k++)
			waiting[k] = 1'b0;
		repeat (16) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check("ready after reset", cpu_req_ready, 1);
		check("bus valid after reset", bus_req_valid, 0);
		check("response valid after reset", cpu_resp_valid, 0);

		send_req(1'b0, 32'h0000_1040, '1, '0, 1);
		wait_resp(1);
		report_test("full line read");

		hs = handshakes;
		send_req(1'b0, 32'h0000_2000, {32'hffff_ffff, 32'h0}, '0, 2);
		wait_resp(2);
		check("upper half bus requests", handshakes - hs, 1);
		report_test("upper half read");

		for (int k = 0; k < 16; k++)
			wdat[32*k +: 32] = $urandom;
		send_req(1'b1, 32'h0000_3000, 64'h00ff_0f0f_f000_ffff, wdat, 3);
		wait_resp(3);
		send_req(1'b0, 32'h0000_3000, '1, '0, 4);
		wait_resp(4);
		report_test("write then read");

		// four slots fill and the fifth has to wait for a retire
		for (int k = 0; k < 4; k++)
			send_req(1'b0, 32'h0001_0000 + 32'(k * 64), '1, '0, 4'(5 + k));
		check("ready with all slots busy", cpu_req_ready, 0);
		send_req(1'b0, 32'h0001_0100, '1, '0, 9);
		for (int k = 5; k < 10; k++)
			wait_resp(k);
		report_test("four in flight");

		hs = handshakes;
		send_req(1'b0, 32'h0000_4000, '0, '0, 10);
		wait_resp(10);
		lat = resp_cyc[10] - acc_cyc[10];
		check("empty request latency", (lat >= 2) && (lat <= 3), 1);
		check("empty request bus requests", handshakes - hs, 0);
		report_test("no byte enables");

		send_req(1'b0, 32'hf000_1000, '1, '0, 11);
		wait_resp(11);
		// hold the answers so a foreign tag hits a half still outstanding
		hold = 1'b1;
		hs = handshakes;
		send_req(1'b0, 32'h0000_5000, '1, '0, 12);
		wait_handshakes(hs + 2);
		@(negedge clk);
		inj_valid = 1'b1;
		inj_tag = {2'd2, 2'd0, 1'b0};
		@(negedge clk);
		inj_valid = 1'b0;
		@(negedge clk);
		hold = 1'b0;
		wait_resp(12);
		report_test("error and foreign tag");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+rtl
rtl/bus_pkg.sv
rtl/req_pkg.sv
rtl/req_queue.sv
rtl/tran_issue.sv
rtl/resp_collect.sv
rtl/dcache_ctrl_top.sv
test/tb_bus_model.sv
test/tb_dcache_ctrl.sv
